// File: verif/mem_pipe_cases.txt
# name op rs1 imm rs2 rd kind expected  (op is the mem_op_e code in hex, rd is decimal)
# kind: none, int, flt, lmis, smis, lacc, sacc; expected is the writeback data in hex
sd_base       a 100              0                f0e1d2c3b4a59687  0 none 0
sb_lane3      7 100              3                1122334455667785  0 none 0
lb_lane3      0 100              3                0                 1 int  ffffffffffffff85
lbu_lane3     4 100              3                0                 2 int  0000000000000085
ld_neg_imm    3 108              fffffffffffffff8 0                 3 int  f0e1d2c385a59687
sh_lane4      8 108              4                aaaabbbbcccc8001  0 none 0
lh_neg        1 108              4                0                 4 int  ffffffffffff8001
lhu_lane4     5 10c              0                0                 5 int  0000000000008001
sw_hi         9 110              4                deadbeef89abcdef  0 none 0
lw_neg        2 110              4                0                 6 int  ffffffff89abcdef
lwu_hi        6 114              0                0                 7 int  0000000089abcdef
fsw_lo        d 118              0                123456783fc00000  0 none 0
flw_box       b 118              0                0                 8 flt  ffffffff3fc00000
fsd_pi        e 120              0                400921fb54442d18  0 none 0
fld_pi        c 120              0                0                 9 flt  400921fb54442d18
sd_mis        a 120              4                ffffffffffffffff  0 smis 0
lw_mis        2 100              2                0                10 lmis 0
ld_chk_mis    3 120              0                0                11 int  400921fb54442d18
lw_fault_hi   2 8000000000000100 0                0                12 lacc 0
sd_fault      a 800              100              0123456789abcdef  0 sacc 0
ld_chk_fault  3 100              0                0                13 int  f0e1d2c385a59687

// File: all.f
+incdir+hdl
hdl/mem_pipe_pkg.sv
hdl/pipe_stage_reg.sv
hdl/mem_agen.sv
hdl/mem_data_array.sv
hdl/mem_load_align.sv
hdl/mem_pipe_top.sv
verif/tb_mem_pipe.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_pipe
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: verif/tb_mem_pipe.sv
`timescale 1ns/1ps
`include "mem_pipe_macros.svh"

module tb_mem_pipe
  import mem_pipe_pkg::*;
  ();

  localparam int accept_limit_lp = 200;
  localparam int drain_limit_lp  = 400;

  logic                              clk_i;
  logic                              reset_i;
  logic                              reservation_v_i;
  mem_op_e                           op_i;
  logic [`MEM_DWORD_WIDTH-1:0]       rs1_i;
  logic [`MEM_DWORD_WIDTH-1:0]       rs2_i;
  logic [`MEM_DWORD_WIDTH-1:0]       imm_i;
  logic [`MEM_REG_ADDR_WIDTH-1:0]    rd_addr_i;
  logic                              ready_o;
  logic                              load_misaligned_v_o;
  logic                              store_misaligned_v_o;
  logic                              load_access_fault_v_o;
  logic                              store_access_fault_v_o;
  wb_pkt_s                           late_iwb_pkt_o;
  logic                              late_iwb_pkt_v_o;
  logic                              late_iwb_pkt_yumi_i = 1'b0;
  wb_pkt_s                           late_fwb_pkt_o;
  logic                              late_fwb_pkt_v_o;
  logic                              late_fwb_pkt_yumi_i = 1'b0;

  // Case table, one entry per line of the cases file
  string                             name_q[$];
  string                             kind_q[$];
  logic [3:0]                        op_q[$];
  logic [`MEM_DWORD_WIDTH-1:0]       rs1_q[$];
  logic [`MEM_DWORD_WIDTH-1:0]       imm_q[$];
  logic [`MEM_DWORD_WIDTH-1:0]       rs2_q[$];
  logic [`MEM_DWORD_WIDTH-1:0]       val_q[$];
  logic [`MEM_REG_ADDR_WIDTH-1:0]    rd_q[$];

  // Outstanding results in issue order
  wb_pkt_s                           wb_exp_q[$];
  logic                              wb_float_q[$];
  string                             wb_name_q[$];
  logic [3:0]                        exc_exp_q[$];
  string                             exc_name_q[$];

  logic                              yumi_int_next = 1'b0;
  logic                              yumi_flt_next = 1'b0;
  logic                              held_v        = 1'b0;
  logic                              held_float    = 1'b0;
  wb_pkt_s                           held_pkt;

  mem_pipe_top uut
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.reservation_v_i(reservation_v_i)
     ,.op_i(op_i)
     ,.rs1_i(rs1_i)
     ,.rs2_i(rs2_i)
     ,.imm_i(imm_i)
     ,.rd_addr_i(rd_addr_i)
     ,.ready_o(ready_o)
     ,.load_misaligned_v_o(load_misaligned_v_o)
     ,.store_misaligned_v_o(store_misaligned_v_o)
     ,.load_access_fault_v_o(load_access_fault_v_o)
     ,.store_access_fault_v_o(store_access_fault_v_o)
     ,.late_iwb_pkt_o(late_iwb_pkt_o)
     ,.late_iwb_pkt_v_o(late_iwb_pkt_v_o)
     ,.late_iwb_pkt_yumi_i(late_iwb_pkt_yumi_i)
     ,.late_fwb_pkt_o(late_fwb_pkt_o)
     ,.late_fwb_pkt_v_o(late_fwb_pkt_v_o)
     ,.late_fwb_pkt_yumi_i(late_fwb_pkt_yumi_i)
     );

  always #20 clk_i = ~clk_i;

  task automatic abort_run(input string msg);
    $display("%0s", msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  // Bit order is load mis, store mis, load fault, store fault
  function automatic logic [3:0] exc_bits_for(input string kind);
    case (kind)
      "lmis":  return 4'b1000;
      "smis":  return 4'b0100;
      "lacc":  return 4'b0010;
      "sacc":  return 4'b0001;
      default: return 4'b0000;
    endcase
  endfunction

  task automatic check_wb(input string name, input wb_pkt_s exp, input wb_pkt_s act);
    if (act !== exp)
      abort_run($sformatf("Error %0s expected rd %0d data %h actual rd %0d data %h",
                          name, exp.rd_addr, exp.rd_data, act.rd_addr, act.rd_data));
  endtask

  task automatic check_exc(input string name, input logic [3:0] exp, input logic [3:0] act);
    if (act !== exp)
      abort_run($sformatf("Error %0s expected exceptions %b actual exceptions %b",
                          name, exp, act));
  endtask

  task automatic load_cases();
    int                              fd;
    int                              fields;
    string                           line;
    string                           name;
    string                           kind;
    logic [3:0]                      op;
    logic [`MEM_DWORD_WIDTH-1:0]     rs1;
    logic [`MEM_DWORD_WIDTH-1:0]     imm;
    logic [`MEM_DWORD_WIDTH-1:0]     rs2;
    logic [`MEM_DWORD_WIDTH-1:0]     val;
    logic [`MEM_REG_ADDR_WIDTH-1:0]  rd;
    fd = $fopen("verif/mem_pipe_cases.txt", "r");
    if (fd == 0)
      abort_run("Cannot open verif/mem_pipe_cases.txt");
    while ($fgets(line, fd) != 0)
      begin
        if (line.len() > 1 && line[0] != "#")
          begin
            fields = $sscanf(line, "%s %h %h %h %h %d %s %h",
                             name, op, rs1, imm, rs2, rd, kind, val);
            if (fields != 8)
              abort_run($sformatf("Malformed line in the cases file: %0s", line));
            if (kind != "none" && kind != "int" && kind != "flt"
                && exc_bits_for(kind) == 4'b0000)
              abort_run($sformatf("Unknown result kind %0s in case %0s", kind, name));
            name_q.push_back(name);
            kind_q.push_back(kind);
            op_q.push_back(op);
            rs1_q.push_back(rs1);
            imm_q.push_back(imm);
            rs2_q.push_back(rs2);
            rd_q.push_back(rd);
            val_q.push_back(val);
          end
      end
    $fclose(fd);
    if (name_q.size() == 0)
      abort_run("The cases file holds no cases");
  endtask

  task automatic expect_result(input int i);
    wb_pkt_s pkt;
    pkt.rd_addr = rd_q[i];
    pkt.rd_data = val_q[i];
    if (kind_q[i] == "int" || kind_q[i] == "flt")
      begin
        wb_exp_q.push_back(pkt);
        wb_float_q.push_back(kind_q[i] == "flt");
        wb_name_q.push_back(name_q[i]);
      end
    else if (kind_q[i] != "none")
      begin
        exc_exp_q.push_back(exc_bits_for(kind_q[i]));
        exc_name_q.push_back(name_q[i]);
      end
  endtask

  // Hold the reservation until the pipe accepts it
  task automatic issue_case(input int i);
    int waited;
    @(posedge clk_i);
    reservation_v_i <= 1'b1;
    op_i            <= mem_op_e'(op_q[i]);
    rs1_i           <= rs1_q[i];
    imm_i           <= imm_q[i];
    rs2_i           <= rs2_q[i];
    rd_addr_i       <= rd_q[i];
    waited = 0;
    @(negedge clk_i);
    while (!ready_o)
      begin
        waited++;
        if (waited == accept_limit_lp)
          abort_run($sformatf("Timed out waiting for ready on case %0s", name_q[i]));
        @(negedge clk_i);
      end
    expect_result(i);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (wb_exp_q.size() != 0 || exc_exp_q.size() != 0)
      begin
        waited++;
        if (waited == drain_limit_lp)
          abort_run("Timed out waiting for outstanding writebacks or exceptions");
        @(negedge clk_i);
      end
  endtask

  always @(posedge clk_i)
    begin
      late_iwb_pkt_yumi_i <= yumi_int_next;
      late_fwb_pkt_yumi_i <= yumi_flt_next;
    end

  // Outputs are sampled mid-cycle, away from the driving edge
  always @(negedge clk_i)
    begin : monitor
      logic [3:0]  exc_bits;
      logic        wb_v;
      logic        wb_float;
      logic        taken;
      logic        exp_float;
      wb_pkt_s     wb_pkt;
      wb_pkt_s     exp_pkt;
      string       name;
      int unsigned rnd;
      if (!reset_i)
        begin
          exc_bits = {load_misaligned_v_o, store_misaligned_v_o,
                      load_access_fault_v_o, store_access_fault_v_o};
          if (exc_bits != 4'b0000)
            begin
              if (exc_exp_q.size() == 0)
                abort_run("Exception pulse with no faulting operation outstanding");
              check_exc(exc_name_q.pop_front(), exc_exp_q.pop_front(), exc_bits);
            end
          if (late_iwb_pkt_v_o && late_fwb_pkt_v_o)
            abort_run("Both writeback valids are high in the same cycle");
          wb_v     = late_iwb_pkt_v_o | late_fwb_pkt_v_o;
          wb_float = late_fwb_pkt_v_o;
          wb_pkt   = wb_float ? late_fwb_pkt_o : late_iwb_pkt_o;
          taken    = wb_float ? late_fwb_pkt_yumi_i : late_iwb_pkt_yumi_i;
          // A packet not yet taken must wait unchanged on its port
          if (held_v && (!wb_v || wb_float != held_float || wb_pkt !== held_pkt))
            abort_run("Writeback packet changed or vanished before it was taken");
          yumi_int_next = 1'b0;
          yumi_flt_next = 1'b0;
          held_v        = wb_v & ~taken;
          held_float    = wb_float;
          held_pkt      = wb_pkt;
          if (wb_v && taken)
            begin
              if (wb_exp_q.size() == 0)
                abort_run("Writeback taken with no load outstanding");
              name      = wb_name_q.pop_front();
              exp_pkt   = wb_exp_q.pop_front();
              exp_float = wb_float_q.pop_front();
              if (exp_float != wb_float)
                abort_run($sformatf("Case %0s came back on the wrong writeback port", name));
              check_wb(name, exp_pkt, wb_pkt);
            end
          else if (held_v)
            begin
              rnd           = $urandom;
              yumi_int_next = rnd[0] & ~wb_float;
              yumi_flt_next = rnd[0] & wb_float;
            end
        end
    end

  initial
    begin
      void'($urandom(32'h2565_5cc6));
      clk_i           = 1'b0;
      reset_i         = 1'b1;
      reservation_v_i = 1'b0;
      op_i            = e_lb;
      rs1_i           = '0;
      rs2_i           = '0;
      imm_i           = '0;
      rd_addr_i       = '0;
      load_cases();
      repeat (4)
        @(posedge clk_i);
      reset_i <= 1'b0;
      @(negedge clk_i);
      if (!ready_o || late_iwb_pkt_v_o || late_fwb_pkt_v_o)
        abort_run("Pipeline is not idle and ready after reset");
      for (int i = 0; i < name_q.size(); i++)
        issue_case(i);
      @(posedge clk_i);
      reservation_v_i <= 1'b0;
      wait_drain();
      // Room for a stray late result to show up
      repeat (8)
        @(negedge clk_i);
      if (late_iwb_pkt_v_o || late_fwb_pkt_v_o)
        abort_run("Writeback valid still high after every expected result was taken");
      else
        begin
          $display("=== PASS ===");
          $finish;
        end
    end

endmodule

// File: hdl/mem_pipe_top.sv
`timescale 1ns/1ps
`include "mem_pipe_macros.svh"

module mem_pipe_top
  import mem_pipe_pkg::*;
  (input                                    clk_i
   , input                                  reset_i

   , input                                  reservation_v_i
   , input mem_op_e                         op_i
   , input [`MEM_DWORD_WIDTH-1:0]           rs1_i
   , input [`MEM_DWORD_WIDTH-1:0]           rs2_i
   , input [`MEM_DWORD_WIDTH-1:0]           imm_i
   , input [`MEM_REG_ADDR_WIDTH-1:0]        rd_addr_i
   , output logic                           ready_o

   , output logic                           load_misaligned_v_o
   , output logic                           store_misaligned_v_o
   , output logic                           load_access_fault_v_o
   , output logic                           store_access_fault_v_o

   , output wb_pkt_s                        late_iwb_pkt_o
   , output logic                           late_iwb_pkt_v_o
   , input                                  late_iwb_pkt_yumi_i
   , output wb_pkt_s                        late_fwb_pkt_o
   , output logic                           late_fwb_pkt_v_o
   , input                                  late_fwb_pkt_yumi_i
   );

  logic                        agen_v;
  agen_pkt_s                   agen_pkt;
  logic                        stage_a_v;
  agen_pkt_s                   stage_a_pkt;
  logic                        stage_b_v_li;
  mem_pkt_s                    stage_b_pkt_li;
  logic                        stage_b_v;
  mem_pkt_s                    stage_b_pkt;
  logic [`MEM_DWORD_WIDTH-1:0] rdata;
  logic                        exc_v;
  logic                        advance;

  // Whole pipe moves together, gated only by the writeback register
  assign advance = ~(late_iwb_pkt_v_o | late_fwb_pkt_v_o)
                   | late_iwb_pkt_yumi_i | late_fwb_pkt_yumi_i;
  assign ready_o = advance;

  mem_agen agen
    (.reservation_v_i(reservation_v_i)
     ,.op_i(op_i)
     ,.rs1_i(rs1_i)
     ,.rs2_i(rs2_i)
     ,.imm_i(imm_i)
     ,.rd_addr_i(rd_addr_i)
     ,.agen_v_o(agen_v)
     ,.agen_pkt_o(agen_pkt)
     );

  pipe_stage_reg #(.payload_t(agen_pkt_s)) stage_a
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.en_i(advance)
     ,.v_i(agen_v)
     ,.data_i(agen_pkt)
     ,.v_o(stage_a_v)
     ,.data_o(stage_a_pkt)
     );

  // Exceptions fire once, as stage A hands off
  assign exc_v                  = stage_a_v & advance;
  assign load_misaligned_v_o    = exc_v & stage_a_pkt.load  & stage_a_pkt.misaligned;
  assign store_misaligned_v_o   = exc_v & stage_a_pkt.store & stage_a_pkt.misaligned;
  assign load_access_fault_v_o  = exc_v & stage_a_pkt.load  & stage_a_pkt.access_fault;
  assign store_access_fault_v_o = exc_v & stage_a_pkt.store & stage_a_pkt.access_fault;

  mem_data_array data_array
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.en_i(advance)
     ,.v_i(stage_a_v)
     ,.pkt_i(stage_a_pkt)
     ,.rdata_o(rdata)
     );

  assign stage_b_v_li = stage_a_v & stage_a_pkt.load
                        & ~stage_a_pkt.misaligned & ~stage_a_pkt.access_fault;
  assign stage_b_pkt_li = '{load      : stage_a_pkt.load
                            ,store    : stage_a_pkt.store
                            ,sign_ext : stage_a_pkt.sign_ext
                            ,float_op : stage_a_pkt.float_op
                            ,size     : stage_a_pkt.size
                            ,rd_addr  : stage_a_pkt.rd_addr
                            ,index    : stage_a_pkt.index
                            ,offset   : stage_a_pkt.offset
                            };

  pipe_stage_reg #(.payload_t(mem_pkt_s)) stage_b
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.en_i(advance)
     ,.v_i(stage_b_v_li)
     ,.data_i(stage_b_pkt_li)
     ,.v_o(stage_b_v)
     ,.data_o(stage_b_pkt)
     );

  mem_load_align load_align
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.v_i(stage_b_v)
     ,.pkt_i(stage_b_pkt)
     ,.rdata_i(rdata)
     ,.iwb_pkt_o(late_iwb_pkt_o)
     ,.iwb_v_o(late_iwb_pkt_v_o)
     ,.iwb_yumi_i(late_iwb_pkt_yumi_i)
     ,.fwb_pkt_o(late_fwb_pkt_o)
     ,.fwb_v_o(late_fwb_pkt_v_o)
     ,.fwb_yumi_i(late_fwb_pkt_yumi_i)
     );

endmodule

// File: hdl/mem_load_align.sv
`timescale 1ns/1ps
`include "mem_pipe_macros.svh"

module mem_load_align
  import mem_pipe_pkg::*;
  (input                                    clk_i
   , input                                  reset_i

   , input                                  v_i
   , input mem_pkt_s                        pkt_i
   , input [`MEM_DWORD_WIDTH-1:0]           rdata_i

   , output wb_pkt_s                        iwb_pkt_o
   , output logic                           iwb_v_o
   , input                                  iwb_yumi_i
   , output wb_pkt_s                        fwb_pkt_o
   , output logic                           fwb_v_o
   , input                                  fwb_yumi_i
   );

  logic [`MEM_DWORD_WIDTH-1:0] shifted;
  logic [`MEM_DWORD_WIDTH-1:0] load_data;
  logic                        byte_sign;
  logic                        half_sign;
  logic                        word_sign;
  logic                        wb_en;
  logic                        wb_v_r;
  logic                        wb_float_r;
  wb_pkt_s                     wb_pkt_r;

  // Bring the addressed bytes down to lane 0
  assign shifted = rdata_i >> {pkt_i.offset, 3'b000};

  assign byte_sign = pkt_i.sign_ext & shifted[7];
  assign half_sign = pkt_i.sign_ext & shifted[15];
  assign word_sign = pkt_i.sign_ext & shifted[31];

  always_comb
    case (pkt_i.size)
      e_size_b: load_data = {{56{byte_sign}}, shifted[7:0]};
      e_size_h: load_data = {{48{half_sign}}, shifted[15:0]};
      // flw gets NaN-boxed with all ones above the word
      e_size_w: load_data = {{32{word_sign | pkt_i.float_op}}, shifted[31:0]};
      default:  load_data = shifted;
    endcase

  // Register is free when empty or drained this cycle
  assign wb_en = ~wb_v_r | iwb_yumi_i | fwb_yumi_i;

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        wb_v_r <= 1'b0;
      else if (wb_en)
        wb_v_r <= v_i & pkt_i.load;
    end

  always_ff @(posedge clk_i)
    begin
      if (wb_en)
        begin
          wb_float_r       <= pkt_i.float_op;
          wb_pkt_r.rd_addr <= pkt_i.rd_addr;
          wb_pkt_r.rd_data <= load_data;
        end
    end

  assign iwb_pkt_o = wb_pkt_r;
  assign fwb_pkt_o = wb_pkt_r;
  assign iwb_v_o   = wb_v_r & ~wb_float_r;
  assign fwb_v_o   = wb_v_r &  wb_float_r;

endmodule

// File: hdl/mem_data_array.sv
`timescale 1ns/1ps
`include "mem_pipe_macros.svh"

module mem_data_array
  import mem_pipe_pkg::*;
  (input                                    clk_i
   , input                                  reset_i
   , input                                  en_i
   , input                                  v_i
   , input agen_pkt_s                       pkt_i

   , output logic [`MEM_DWORD_WIDTH-1:0]    rdata_o
   );

  localparam int bytes_lp = `MEM_DWORD_WIDTH / 8;

  logic [bytes_lp-1:0][7:0] mem_r [`MEM_DEPTH_DWORDS];
  logic [bytes_lp-1:0]      size_mask;
  logic [bytes_lp-1:0]      byte_en;
  logic                     w_v;
  logic                     r_v;

  always_comb
    case (pkt_i.size)
      e_size_b: size_mask = 8'h01;
      e_size_h: size_mask = 8'h03;
      e_size_w: size_mask = 8'h0f;
      default:  size_mask = 8'hff;
    endcase

  assign byte_en = size_mask << pkt_i.offset;

  // Faulting stores never touch the array
  assign w_v = en_i & v_i & pkt_i.store & ~pkt_i.misaligned & ~pkt_i.access_fault & ~reset_i;
  assign r_v = en_i & v_i & pkt_i.load;

  always_ff @(posedge clk_i)
    begin
      if (w_v)
        begin
          for (int i = 0; i < bytes_lp; i++)
            begin
              if (byte_en[i])
                mem_r[pkt_i.index][i] <= pkt_i.data[8*i+:8];
            end
        end
    end

  // Read data holds while the pipe is stalled
  always_ff @(posedge clk_i)
    begin
      if (r_v)
        rdata_o <= mem_r[pkt_i.index];
    end

endmodule

// File: hdl/mem_agen.sv
`timescale 1ns/1ps
`include "mem_pipe_macros.svh"

module mem_agen
  import mem_pipe_pkg::*;
  (input                                    reservation_v_i
   , input mem_op_e                         op_i
   , input [`MEM_DWORD_WIDTH-1:0]           rs1_i
   , input [`MEM_DWORD_WIDTH-1:0]           rs2_i
   , input [`MEM_DWORD_WIDTH-1:0]           imm_i
   , input [`MEM_REG_ADDR_WIDTH-1:0]        rd_addr_i

   , output logic                           agen_v_o
   , output agen_pkt_s                      agen_pkt_o
   );

  localparam int range_lsb_lp = `MEM_INDEX_WIDTH + `MEM_OFFSET_WIDTH;

  logic [`MEM_EADDR_WIDTH-1:0]  eaddr;
  logic [`MEM_OFFSET_WIDTH-1:0] offset;
  logic [`MEM_DWORD_WIDTH-1:0]  store_data;
  logic                         load;
  logic                         store;
  logic                         sign_ext;
  logic                         float_op;
  logic                         misaligned;
  logic                         out_of_range;
  mem_size_e                    size;

  assign eaddr  = rs1_i + imm_i;
  assign offset = eaddr[`MEM_OFFSET_WIDTH-1:0];

  assign load     = op_i inside {e_lb, e_lh, e_lw, e_ld, e_lbu, e_lhu, e_lwu, e_flw, e_fld};
  assign store    = op_i inside {e_sb, e_sh, e_sw, e_sd, e_fsw, e_fsd};
  assign sign_ext = op_i inside {e_lb, e_lh, e_lw, e_ld};
  assign float_op = op_i inside {e_flw, e_fld, e_fsw, e_fsd};

  always_comb
    case (op_i)
      e_lb, e_lbu, e_sb:               size = e_size_b;
      e_lh, e_lhu, e_sh:               size = e_size_h;
      e_lw, e_lwu, e_sw, e_flw, e_fsw: size = e_size_w;
      default:                         size = e_size_d;
    endcase

  always_comb
    case (size)
      e_size_b: misaligned = 1'b0;
      e_size_h: misaligned = offset[0];
      e_size_w: misaligned = |offset[1:0];
      default:  misaligned = |offset;
    endcase

  // Anything past the local 2 KiB faults
  assign out_of_range = |eaddr[`MEM_EADDR_WIDTH-1:range_lsb_lp];

  // Replicate store data so every lane holds it
  always_comb
    case (size)
      e_size_b: store_data = {8{rs2_i[7:0]}};
      e_size_h: store_data = {4{rs2_i[15:0]}};
      e_size_w: store_data = {2{rs2_i[31:0]}};
      default:  store_data = rs2_i;
    endcase

  assign agen_v_o = reservation_v_i & (load | store);

  assign agen_pkt_o = '{load         : load
                        ,store        : store
                        ,sign_ext     : sign_ext
                        ,float_op     : float_op
                        ,size         : size
                        ,rd_addr      : rd_addr_i
                        ,index        : eaddr[range_lsb_lp-1:`MEM_OFFSET_WIDTH]
                        ,offset       : offset
                        ,data         : store_data
                        ,misaligned   : misaligned
                        ,access_fault : ~misaligned & out_of_range
                        };

endmodule

// File: hdl/pipe_stage_reg.sv
`timescale 1ns/1ps

module pipe_stage_reg
  #(parameter type payload_t = logic)
  (input                clk_i
   , input              reset_i
   , input              en_i
   , input              v_i
   , input payload_t    data_i
   , output logic       v_o
   , output payload_t   data_o
   );

  logic     v_r;
  payload_t data_r;

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        v_r <= 1'b0;
      else if (en_i)
        v_r <= v_i;
    end

  // Payload only moves with the pipeline
  always_ff @(posedge clk_i)
    begin
      if (en_i)
        data_r <= data_i;
    end

  assign v_o    = v_r;
  assign data_o = data_r;

endmodule

// File: hdl/mem_pipe_pkg.sv
`include "mem_pipe_macros.svh"

package mem_pipe_pkg;

  typedef enum logic [3:0]
  {
    e_lb    = 4'h0
    , e_lh  = 4'h1
    , e_lw  = 4'h2
    , e_ld  = 4'h3
    , e_lbu = 4'h4
    , e_lhu = 4'h5
    , e_lwu = 4'h6
    , e_sb  = 4'h7
    , e_sh  = 4'h8
    , e_sw  = 4'h9
    , e_sd  = 4'ha
    , e_flw = 4'hb
    , e_fld = 4'hc
    , e_fsw = 4'hd
    , e_fsd = 4'he
  } mem_op_e;

  typedef enum logic [1:0]
  {
    e_size_b   = 2'b00
    , e_size_h = 2'b01
    , e_size_w = 2'b10
    , e_size_d = 2'b11
  } mem_size_e;

  // Agen to memory stage
  typedef struct packed
  {
    logic                            load;
    logic                            store;
    logic                            sign_ext;
    logic                            float_op;
    mem_size_e                       size;
    logic [`MEM_REG_ADDR_WIDTH-1:0]  rd_addr;
    logic [`MEM_INDEX_WIDTH-1:0]     index;
    logic [`MEM_OFFSET_WIDTH-1:0]    offset;
    logic [`MEM_DWORD_WIDTH-1:0]     data;
    logic                            misaligned;
    logic                            access_fault;
  } agen_pkt_s;

  // Memory to align stage
  typedef struct packed
  {
    logic                            load;
    logic                            store;
    logic                            sign_ext;
    logic                            float_op;
    mem_size_e                       size;
    logic [`MEM_REG_ADDR_WIDTH-1:0]  rd_addr;
    logic [`MEM_INDEX_WIDTH-1:0]     index;
    logic [`MEM_OFFSET_WIDTH-1:0]    offset;
  } mem_pkt_s;

  typedef struct packed
  {
    logic [`MEM_REG_ADDR_WIDTH-1:0]  rd_addr;
    logic [`MEM_DWORD_WIDTH-1:0]     rd_data;
  } wb_pkt_s;

endpackage

// File: hdl/mem_pipe_macros.svh
`ifndef MEM_PIPE_MACROS_SVH
`define MEM_PIPE_MACROS_SVH

// Datapath and register file
`define MEM_DWORD_WIDTH     64
`define MEM_EADDR_WIDTH     64
`define MEM_REG_ADDR_WIDTH  5

// 2 KiB local data memory
`define MEM_DEPTH_DWORDS    256
`define MEM_INDEX_WIDTH     8
`define MEM_OFFSET_WIDTH    3

`endif
